// File: Makefile
# Verilator build and run for the 16-bit accumulator core
# A failing run ends in $fatal, so make sim returns a non-zero status

VERILATOR ?= verilator
TOP       ?= tb_cpu16
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+hw
hw/cpu16_pkg.sv
hw/uop_if.sv
hw/instr_decoder.sv
hw/sequencer.sv
hw/alu_status.sv
hw/acc_file.sv
hw/cpu16_top.sv
tb/tb_cpu16.sv

// File: hw/acc_file.sv
// Accumulator file A to D
// Result written to dst at DECODE, src read back continuously
`timescale 1ns/1ps
`default_nettype none

module acc_file (
	input  logic clk,
	input  logic reset,
	uop_if.datapath uop,
	input  logic decode_en,			// Commit slot
	input  cpu16_pkg::word_t result,	// Registered ALU output
	output cpu16_pkg::word_t rd_data
);

	cpu16_pkg::word_t acc [4];		// Indexed by acc_sel_t
	logic wr_en;

	assign wr_en = decode_en && uop.load_reg;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				acc[i] <= '0;
		end else if (wr_en) begin
			acc[uop.dst] <= result;
		end
	end

	assign rd_data = acc[uop.src];	// Store data and ALU operand

	// BOOT comes first, so nothing commits right after reset
	a_no_early_write: assert property (@(posedge clk)
		$fell(reset) |-> !wr_en);

endmodule

`default_nettype wire

// File: hw/alu_status.sv
// ALU and status flags
// Registered result on alu_en, N V Z C commit on decode_en, branch test
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_config.svh"

module alu_status (
	input  logic clk,
	input  logic reset,
	uop_if.datapath uop,
	input  logic decode_en,			// Commit flags
	input  logic alu_en,			// Register result
	input  cpu16_pkg::word_t operand,	// Source accumulator
	input  cpu16_pkg::word_t rdata,		// Immediate word
	output cpu16_pkg::word_t result,
	output logic take_branch
);

	localparam int MSB = `CPU16_DATA_W - 1;

	cpu16_pkg::word_t a_in;
	cpu16_pkg::word_t b_in;
	cpu16_pkg::word_t alu_out;
	logic [`CPU16_DATA_W:0] sum;		// Extra bit is carry out
	logic cin;
	logic cout;
	logic ovf;
	logic alu_c;				// Registered ALU flags
	logic alu_v;
	logic alu_n;
	logic alu_z;
	logic flag_n;				// Status register
	logic flag_v;
	logic flag_z;
	logic flag_c;
	logic flag_sel;

	assign a_in = uop.load_only ? '0 : operand;
	assign b_in = (uop.alu_op == cpu16_pkg::ALU_SUB) ? ~rdata : rdata;
	assign cin = uop.carry_mode[1] ? flag_c : uop.carry_mode[0];
	assign sum = {1'b0, a_in} + {1'b0, b_in} + cin;

	always_comb begin
		cout = 1'b0;
		case (uop.alu_op)
			cpu16_pkg::ALU_OR: alu_out = a_in | b_in;
			cpu16_pkg::ALU_AND: alu_out = a_in & b_in;
			cpu16_pkg::ALU_EOR: alu_out = a_in ^ b_in;
			cpu16_pkg::ALU_ADD,
			cpu16_pkg::ALU_SUB: begin
				alu_out = sum[MSB:0];
				cout = sum[`CPU16_DATA_W];	// SUB: set means no borrow
			end
			default: alu_out = a_in;		// Transfer
		endcase
	end

	// Same-sign operands giving a different-sign sum
	assign ovf = (a_in[MSB] == b_in[MSB]) && (sum[MSB] != a_in[MSB]);

	always_ff @(posedge clk) begin
		if (alu_en) begin
			result <= alu_out;
			alu_c <= cout;
			alu_v <= ovf;
			alu_n <= alu_out[MSB];
			alu_z <= ~|alu_out;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flag_n <= 1'b0;
			flag_v <= 1'b0;
			flag_z <= 1'b0;
			flag_c <= 1'b0;
		end else if (decode_en) begin
			if (uop.sets_nz) begin
				flag_n <= alu_n;
				flag_z <= alu_z;
			end
			if (uop.sets_cv)
				flag_c <= alu_c;
			if (uop.sets_cv && uop.load_reg)
				flag_v <= alu_v;	// ADC, SBC only; CMP keeps V
			if (uop.clc)
				flag_c <= 1'b0;
			if (uop.sec)
				flag_c <= 1'b1;
			if (uop.clv)
				flag_v <= 1'b0;
		end
	end

	// Code pairs N V C Z, odd code tests for set
	always_comb begin
		case (uop.cond[2:1])
			2'd0: flag_sel = flag_n;
			2'd1: flag_sel = flag_v;
			2'd2: flag_sel = flag_c;
			default: flag_sel = flag_z;
		endcase
	end

	assign take_branch = ~(flag_sel ^ uop.cond[0]);

endmodule

`default_nettype wire

// File: hw/cpu16_config.svh
// Build constants for the 16-bit accumulator core
// Widths, reset vector and the opcode low bytes that are recognised
`ifndef CPU16_CONFIG_SVH
`define CPU16_CONFIG_SVH

`define CPU16_DATA_W		16		// Data word
`define CPU16_ADDR_W		32		// Word address
`define CPU16_RESET_VEC		32'h0000_0100	// First opcode fetch

// Immediate group, src in 11:10 and dst in 9:8
`define CPU16_OPC_ORA		8'h09
`define CPU16_OPC_AND		8'h29
`define CPU16_OPC_EOR		8'h49
`define CPU16_OPC_ADC		8'h69
`define CPU16_OPC_LDA		8'hA9
`define CPU16_OPC_CMP		8'hC9
`define CPU16_OPC_SBC		8'hE9

`define CPU16_OPC_TRANSFER	8'h8B		// Tsd
`define CPU16_OPC_STORE_ABS	8'h8D		// Store src to absolute
`define CPU16_OPC_CLC		8'h18
`define CPU16_OPC_SEC		8'h38
`define CPU16_OPC_CLV		8'hB8
`define CPU16_OPC_BRANCH_MASK	8'h1F		// Condition code in 7:5 ignored
`define CPU16_OPC_BRANCH	8'h10

`endif

// File: hw/cpu16_pkg.sv
// Common types for the 16-bit accumulator core
// Word and address vectors, selectors and FSM encodings
`default_nettype none
`include "cpu16_config.svh"

package cpu16_pkg;

	typedef logic [`CPU16_DATA_W-1:0] word_t;	// Data bus word
	typedef logic [`CPU16_ADDR_W-1:0] addr_t;	// Word address
	typedef logic [2:0] cond_t;			// Branch condition code

	// Accumulator index, same order as opcode bits
	typedef enum logic [1:0] {
		ACC_A,
		ACC_B,
		ACC_C,
		ACC_D
	} acc_sel_t;

	typedef enum logic [2:0] {
		ALU_OR,
		ALU_AND,
		ALU_EOR,
		ALU_ADD,
		ALU_SUB,	// B input inverted
		ALU_PASS	// A input straight through
	} alu_op_t;

	typedef enum logic [2:0] {
		BOOT,		// Fetch at reset vector
		DECODE,		// Opcode on rdata, commit previous result
		FETCH,		// Operand or next opcode fetch
		REG,		// Register-only cycle
		ABS0,		// Low address word
		ABS1,		// High address word, write
		BRA0		// Offset on rdata, redirect
	} state_t;

endpackage

`default_nettype wire

// File: hw/cpu16_top.sv
// 16-bit accumulator core, top level
// Decoder, sequencer and datapath on a plain synchronous memory bus
`timescale 1ns/1ps
`default_nettype none

module cpu16_top (
	input  logic clk,
	input  logic reset,
	output cpu16_pkg::addr_t addr,		// Word address
	input  cpu16_pkg::word_t rdata,		// Data of previous addr
	output cpu16_pkg::word_t wdata,		// Store data
	output logic we
);

	uop_if uop_bus ();			// Decoded fields

	logic decode_en;
	logic alu_en;
	logic take_branch;
	cpu16_pkg::word_t alu_result;

	instr_decoder instr_decoder_i (
		.clk		(clk),
		.reset		(reset),
		.decode_en	(decode_en),
		.rdata		(rdata),
		.uop		(uop_bus)
	);

	sequencer sequencer_i (
		.clk		(clk),
		.reset		(reset),
		.rdata		(rdata),
		.uop		(uop_bus),
		.take_branch	(take_branch),
		.decode_en	(decode_en),
		.alu_en		(alu_en),
		.addr		(addr),
		.we		(we)
	);

	alu_status alu_status_i (
		.clk		(clk),
		.reset		(reset),
		.uop		(uop_bus),
		.decode_en	(decode_en),
		.alu_en		(alu_en),
		.operand	(wdata),	// Accumulator read port
		.rdata		(rdata),
		.result		(alu_result),
		.take_branch	(take_branch)
	);

	acc_file acc_file_i (
		.clk		(clk),
		.reset		(reset),
		.uop		(uop_bus),
		.decode_en	(decode_en),
		.result		(alu_result),
		.rd_data	(wdata)
	);

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
// Instruction decoder
// Matches the opcode low byte and registers the control fields on decode_en
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_config.svh"

module instr_decoder (
	input  logic clk,
	input  logic reset,
	input  logic decode_en,			// DECODE cycle strobe
	input  cpu16_pkg::word_t rdata,		// Opcode word
	uop_if.decoder uop
);

	logic [7:0] opc;			// Low byte picks the instruction
	logic is_branch;

	assign opc = rdata[7:0];
	assign is_branch = (opc & `CPU16_OPC_BRANCH_MASK) == `CPU16_OPC_BRANCH;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			uop.alu_op <= cpu16_pkg::ALU_PASS;
			uop.src <= cpu16_pkg::ACC_A;
			uop.dst <= cpu16_pkg::ACC_A;
			uop.load_reg <= 1'b0;
			uop.load_only <= 1'b0;
			uop.carry_mode <= 2'b00;
			uop.sets_nz <= 1'b0;
			uop.sets_cv <= 1'b0;
			uop.clc <= 1'b0;
			uop.sec <= 1'b0;
			uop.clv <= 1'b0;
			uop.store <= 1'b0;
			uop.branch <= 1'b0;
			uop.reg_op <= 1'b0;
			uop.cond <= '0;
		end else if (decode_en) begin
			// Field slices are taken for every opcode
			uop.src <= cpu16_pkg::acc_sel_t'(rdata[11:10]);
			uop.dst <= cpu16_pkg::acc_sel_t'(rdata[9:8]);
			uop.cond <= rdata[7:5];
			// Defaults, overridden below
			uop.alu_op <= cpu16_pkg::ALU_PASS;
			uop.load_reg <= 1'b0;
			uop.load_only <= 1'b0;
			uop.carry_mode <= 2'b00;
			uop.sets_nz <= 1'b0;
			uop.sets_cv <= 1'b0;
			uop.clc <= 1'b0;
			uop.sec <= 1'b0;
			uop.clv <= 1'b0;
			uop.store <= 1'b0;
			uop.branch <= is_branch;
			uop.reg_op <= 1'b0;
			if (!is_branch) begin
				case (opc)
					`CPU16_OPC_ORA,
					`CPU16_OPC_AND,
					`CPU16_OPC_EOR: begin
						// Logic op in bits 6:5, as OR, AND, EOR order
						uop.alu_op <= cpu16_pkg::alu_op_t'({1'b0, opc[6:5]});
						uop.load_reg <= 1'b1;
						uop.sets_nz <= 1'b1;
					end
					`CPU16_OPC_ADC,
					`CPU16_OPC_SBC: begin
						uop.alu_op <= opc[7] ? cpu16_pkg::ALU_SUB : cpu16_pkg::ALU_ADD;
						uop.load_reg <= 1'b1;
						uop.carry_mode <= 2'b10;	// Chain through C
						uop.sets_nz <= 1'b1;
						uop.sets_cv <= 1'b1;
					end
					`CPU16_OPC_CMP: begin
						uop.alu_op <= cpu16_pkg::ALU_SUB;
						uop.carry_mode <= 2'b01;	// No borrow in
						uop.sets_nz <= 1'b1;
						uop.sets_cv <= 1'b1;
					end
					`CPU16_OPC_LDA: begin
						uop.alu_op <= cpu16_pkg::ALU_OR;	// 0 | imm
						uop.load_only <= 1'b1;
						uop.load_reg <= 1'b1;
						uop.sets_nz <= 1'b1;
					end
					`CPU16_OPC_TRANSFER: begin
						uop.load_reg <= 1'b1;	// PASS of src
						uop.sets_nz <= 1'b1;
						uop.reg_op <= 1'b1;
					end
					`CPU16_OPC_STORE_ABS: uop.store <= 1'b1;
					`CPU16_OPC_CLC: begin
						uop.clc <= 1'b1;
						uop.reg_op <= 1'b1;
					end
					`CPU16_OPC_SEC: begin
						uop.sec <= 1'b1;
						uop.reg_op <= 1'b1;
					end
					`CPU16_OPC_CLV: begin
						uop.clv <= 1'b1;
						uop.reg_op <= 1'b1;
					end
					default: uop.reg_op <= 1'b1;	// Unknown, no-op
				endcase
			end
		end
	end

	// The sequencer dispatch relies on at most one path flag
	a_one_path: assert property (@(posedge clk) disable iff (reset)
		!(uop.store && uop.branch));

endmodule

`default_nettype wire

// File: hw/sequencer.sv
// Core sequencer
// FSM, program counter, address bus and write enable
// First cycle after DECODE is picked from the registered decoder fields
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_config.svh"

module sequencer (
	input  logic clk,
	input  logic reset,
	input  cpu16_pkg::word_t rdata,		// Memory read data
	uop_if.sequencer uop,
	input  logic take_branch,		// Condition true, from flags
	output logic decode_en,
	output logic alu_en,
	output cpu16_pkg::addr_t addr,
	output logic we
);

	cpu16_pkg::state_t state_q;		// Registered state
	cpu16_pkg::state_t state;		// Effective state this cycle
	cpu16_pkg::state_t state_d;
	logic dispatch;				// Cycle right after DECODE
	cpu16_pkg::addr_t pc;			// Next word to fetch
	cpu16_pkg::addr_t offset;		// Branch displacement
	cpu16_pkg::word_t abs_lo;		// Held low address word
	logic pc_hold;

	// Path selection once the decoder registers are loaded
	always_comb begin
		if (!dispatch)
			state = state_q;
		else if (uop.store)
			state = cpu16_pkg::ABS0;
		else if (uop.branch)
			state = cpu16_pkg::BRA0;
		else if (uop.reg_op)
			state = cpu16_pkg::REG;
		else
			state = cpu16_pkg::FETCH;	// Immediate operand
	end

	always_comb begin
		case (state)
			cpu16_pkg::BOOT,
			cpu16_pkg::FETCH,
			cpu16_pkg::REG,
			cpu16_pkg::BRA0: state_d = cpu16_pkg::DECODE;
			cpu16_pkg::DECODE: state_d = cpu16_pkg::FETCH;	// Overridden by dispatch
			cpu16_pkg::ABS0: state_d = cpu16_pkg::ABS1;
			cpu16_pkg::ABS1: state_d = cpu16_pkg::FETCH;
			default: state_d = cpu16_pkg::BOOT;
		endcase
	end

	// Sign-extended offset only when the condition holds
	assign offset = take_branch ?
		{{(`CPU16_ADDR_W-`CPU16_DATA_W){rdata[`CPU16_DATA_W-1]}}, rdata} : '0;

	// Address mux, PC follows addr + 1 unless held
	always_comb begin
		pc_hold = 1'b0;
		case (state)
			cpu16_pkg::REG: begin
				addr = pc - 1'b1;	// Refetch next opcode
				pc_hold = 1'b1;
			end
			cpu16_pkg::ABS1: begin
				addr = {rdata, abs_lo};	// High word from memory
				pc_hold = 1'b1;
			end
			cpu16_pkg::BRA0: addr = pc + offset;
			default: addr = pc;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= cpu16_pkg::BOOT;
			dispatch <= 1'b0;
			pc <= `CPU16_RESET_VEC;
		end else begin
			state_q <= state_d;
			dispatch <= (state == cpu16_pkg::DECODE);
			if (!pc_hold)
				pc <= addr + 1'b1;
		end
	end

	// Low address word captured in ABS0
	always_ff @(posedge clk) begin
		if (state == cpu16_pkg::ABS0)
			abs_lo <= rdata;
	end

	assign decode_en = (state == cpu16_pkg::DECODE);
	assign alu_en = (state == cpu16_pkg::FETCH) || (state == cpu16_pkg::REG);
	assign we = (state == cpu16_pkg::ABS1);	// Only the store path writes

	// Write only in the registered ABS1 of a decoded store
	a_we_in_store: assert property (@(posedge clk) disable iff (reset)
		we |-> (state_q == cpu16_pkg::ABS1) && uop.store);

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {cpu16_pkg::BOOT, cpu16_pkg::DECODE, cpu16_pkg::FETCH,
			cpu16_pkg::REG, cpu16_pkg::ABS0, cpu16_pkg::ABS1, cpu16_pkg::BRA0});

endmodule

`default_nettype wire

// File: hw/uop_if.sv
// Decoded instruction fields
// Filled by the decoder at each DECODE, read by sequencer and datapath
`timescale 1ns/1ps
`default_nettype none

interface uop_if;

	cpu16_pkg::alu_op_t alu_op;	// ALU function
	cpu16_pkg::acc_sel_t src;	// Read accumulator
	cpu16_pkg::acc_sel_t dst;	// Written accumulator
	logic load_reg;			// Result goes to dst
	logic load_only;		// A input forced to zero
	logic [1:0] carry_mode;		// 1x carry flag, 01 one, 00 zero
	logic sets_nz;
	logic sets_cv;
	logic clc;
	logic sec;
	logic clv;
	logic store;			// Absolute store path
	logic branch;			// Conditional branch path
	logic reg_op;			// Single register cycle
	cpu16_pkg::cond_t cond;

	modport decoder (output alu_op, src, dst, load_reg, load_only, carry_mode,
		sets_nz, sets_cv, clc, sec, clv, store, branch, reg_op, cond);

	modport sequencer (input store, branch, reg_op);

	modport datapath (input alu_op, src, dst, load_reg, load_only, carry_mode,
		sets_nz, sets_cv, clc, sec, clv, cond);

endinterface

`default_nettype wire

// File: tb/tb_cpu16.sv
// Testbench for the 16-bit accumulator core
// Random program built at a moving frontier, reference model of every
// instruction, and a check of addr, we and wdata in every cycle
`timescale 1ns/1ps
`default_nettype none
`include "cpu16_config.svh"

module tb_cpu16;

	localparam int NUM_INSTR = 2000;
	localparam int CYCLE_LIMIT = 4 * NUM_INSTR + 50;	// At most 4 cycles per instruction
	localparam int LOOKAHEAD = 8;				// Expected cycles kept ahead

	logic clk;
	logic reset;
	cpu16_pkg::addr_t addr;
	cpu16_pkg::word_t rdata = '0;
	cpu16_pkg::word_t wdata;
	logic we;

	cpu16_pkg::word_t prog [cpu16_pkg::addr_t];	// Generated program words
	cpu16_pkg::word_t data [cpu16_pkg::addr_t];	// Words written by the DUT
	cpu16_pkg::addr_t addr_q = '0;			// Address of the previous cycle
	int cycles = 0;
	integer seed;

	cpu16_pkg::word_t acc [4];		// Model accumulators A to D
	logic f_n;				// Model flags
	logic f_v;
	logic f_z;
	logic f_c;
	cpu16_pkg::addr_t frontier;		// Next opcode address
	int n_gen;

	// Expected bus, one entry per cycle
	string exp_name [$];
	cpu16_pkg::addr_t exp_addr [$];
	logic exp_we [$];
	cpu16_pkg::word_t exp_wdata [$];

	cpu16_top cpu16_top_i (
		.clk	(clk),
		.reset	(reset),
		.addr	(addr),
		.rdata	(rdata),
		.wdata	(wdata),
		.we	(we)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Written data first, then program, else a fill pattern
	function automatic cpu16_pkg::word_t fetch_word(input cpu16_pkg::addr_t a);
		if (data.exists(a))
			return data[a];
		else if (prog.exists(a))
			return prog[a];
		else
			return a[15:0] ^ a[31:16] ^ 16'hC3A5;
	endfunction

	// Synchronous memory, one cycle read latency
	always @(posedge clk) begin
		if (we)
			data[addr] = wdata;
		addr_q <= addr;
	end

	always @(negedge clk)
		rdata <= fetch_word(addr_q);	// Word at last cycle's addr

	always @(posedge clk) begin
		if (!reset) begin
			cycles <= cycles + 1;
			if (cycles >= CYCLE_LIMIT) begin
				$display("timeout: run still going after %0d cycles", cycles);
				$display("TB FAILED");
				$fatal(1, "cycle limit reached");
			end
		end
	end

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %h actual %h", what, expected, actual);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic expect_cycle(input string name, input cpu16_pkg::addr_t a,
		input logic w, input cpu16_pkg::word_t d);
		exp_name.push_back(name);
		exp_addr.push_back(a);
		exp_we.push_back(w);
		exp_wdata.push_back(d);
	endtask

	task automatic put_word(input cpu16_pkg::word_t w);
		prog[frontier] = w;
		frontier = frontier + 32'd1;
	endtask

	// Unsigned carry and signed range give C and V
	function automatic cpu16_pkg::word_t add_with_carry(input cpu16_pkg::word_t a,
		input cpu16_pkg::word_t b, input logic cin, output logic c_out, output logic v_out);
		int u;
		int s;
		u = int'(a) + int'(b) + int'(cin);
		s = int'($signed(a)) + int'($signed(b)) + int'(cin);
		c_out = u > 65535;
		v_out = (s > 32767) || (s < -32768);
		return 16'(u);
	endfunction

	function automatic logic branch_taken(input logic [2:0] cond);
		case (cond)
			3'd0: return !f_n;	// BPL
			3'd1: return f_n;	// BMI
			3'd2: return !f_v;	// BVC
			3'd3: return f_v;	// BVS
			3'd4: return !f_c;	// BCC
			3'd5: return f_c;	// BCS
			3'd6: return !f_z;	// BNE
			default: return f_z;	// BEQ
		endcase
	endfunction

	// Writes one instruction at the frontier, runs it on the model, queues its cycles
	task automatic emit_instruction();
		int kind;
		int src;
		int dst;
		int offset;
		logic [7:0] upper;
		logic [7:0] low;
		logic [2:0] cond;
		logic c_new;
		logic v_new;
		cpu16_pkg::word_t imm;
		cpu16_pkg::word_t res;
		cpu16_pkg::word_t lo_word;
		cpu16_pkg::word_t hi_word;
		cpu16_pkg::addr_t opc_addr;
		string tag;

		opc_addr = frontier;
		upper = 8'($random(seed));
		src = int'(upper[3:2]);
		dst = int'(upper[1:0]);
		kind = $random(seed) & 15;
		tag = $sformatf("instr %0d at %h", n_gen, opc_addr);
		expect_cycle({tag, " decode"}, opc_addr + 32'd1, 1'b0, '0);
		if (kind < 7) begin
			// Operand equal to the source now and then, for Z
			imm = (($random(seed) & 3) == 0) ? acc[src] : 16'($random(seed));
			res = '0;
			low = `CPU16_OPC_LDA;
			case (kind)
				0: begin
					low = `CPU16_OPC_ORA;
					res = acc[src] | imm;
				end
				1: begin
					low = `CPU16_OPC_AND;
					res = acc[src] & imm;
				end
				2: begin
					low = `CPU16_OPC_EOR;
					res = acc[src] ^ imm;
				end
				3: begin
					low = `CPU16_OPC_ADC;
					res = add_with_carry(acc[src], imm, f_c, c_new, v_new);
					f_c = c_new;
					f_v = v_new;
				end
				4: res = imm;		// LDA
				5: begin
					low = `CPU16_OPC_CMP;
					res = add_with_carry(acc[src], ~imm, 1'b1, c_new, v_new);
					f_c = c_new;	// V untouched
				end
				default: begin
					low = `CPU16_OPC_SBC;
					res = add_with_carry(acc[src], ~imm, f_c, c_new, v_new);
					f_c = c_new;
					f_v = v_new;
				end
			endcase
			put_word({upper, low});
			put_word(imm);
			f_n = res[15];
			f_z = (res == '0);
			if (kind != 5)
				acc[dst] = res;
			expect_cycle({tag, " operand"}, frontier, 1'b0, '0);
		end else if (kind < 9) begin
			put_word({upper, `CPU16_OPC_TRANSFER});
			acc[dst] = acc[src];
			f_n = acc[dst][15];
			f_z = (acc[dst] == '0);
			expect_cycle({tag, " transfer"}, frontier, 1'b0, '0);
		end else if (kind == 9) begin
			case ($random(seed) & 3)
				0: begin
					put_word({upper, `CPU16_OPC_CLC});
					f_c = 1'b0;
				end
				2: begin
					put_word({upper, `CPU16_OPC_CLV});
					f_v = 1'b0;
				end
				default: begin
					put_word({upper, `CPU16_OPC_SEC});	// Twice as likely
					f_c = 1'b1;
				end
			endcase
			expect_cycle({tag, " flag op"}, frontier, 1'b0, '0);
		end else if (kind < 13) begin
			cond = 3'($random(seed));
			offset = $random(seed) & 7;
			put_word({upper, cond, 5'h10});
			put_word(16'(offset));
			if (branch_taken(cond))
				frontier = frontier + 32'(offset);	// Skipped words never fetched
			expect_cycle({tag, " branch target"}, frontier, 1'b0, '0);
		end else begin
			lo_word = 16'($random(seed));
			hi_word = 16'($random(seed));
			if (hi_word == '0)
				hi_word = 16'h0001;	// Keep clear of the program
			put_word({upper, `CPU16_OPC_STORE_ABS});
			put_word(lo_word);
			put_word(hi_word);
			expect_cycle({tag, " store low"}, opc_addr + 32'd2, 1'b0, '0);
			expect_cycle({tag, " store write"}, {hi_word, lo_word}, 1'b1, acc[src]);
			expect_cycle({tag, " store next"}, frontier, 1'b0, '0);
		end
		n_gen++;
	endtask

	initial begin : stimulus
		string name;
		cpu16_pkg::addr_t e_addr;
		logic e_we;
		cpu16_pkg::word_t e_wdata;

		seed = 27800;
		reset = 1'b1;
		for (int i = 0; i < 4; i++)
			acc[i] = '0;
		f_n = 1'b0;
		f_v = 1'b0;
		f_z = 1'b0;
		f_c = 1'b0;
		frontier = `CPU16_RESET_VEC;
		n_gen = 0;
		expect_cycle("boot fetch", `CPU16_RESET_VEC, 1'b0, '0);
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (n_gen < NUM_INSTR || exp_addr.size() > 0) begin
			@(posedge clk);
			while (exp_addr.size() < LOOKAHEAD && n_gen < NUM_INSTR)
				emit_instruction();
			name = exp_name.pop_front();
			e_addr = exp_addr.pop_front();
			e_we = exp_we.pop_front();
			e_wdata = exp_wdata.pop_front();
			compare({name, " addr"}, e_addr, addr);
			compare({name, " we"}, {31'd0, e_we}, {31'd0, we});
			if (e_we)
				compare({name, " wdata"}, {16'd0, e_wdata}, {16'd0, wdata});
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire
